/* sources.f */
logic/mem_types_pkg.sv
logic/seq_pkg.sv
logic/mem_port_if.sv
logic/lane_if.sv
logic/access_sequencer.sv
logic/lane_merge.sv
logic/word_memory.sv
logic/mem_access_top.sv
tests/access_checker.sv
tests/tb_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_top -Mdir build
	./build/Vtb_top | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf build sim.log

/* tests/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top;
    import mem_types_pkg::*;

    localparam int MEM_WORDS    = 16;
    localparam int READ_LATENCY = 2;
    // Commands over all five tests
    localparam int NUM_CMDS     = 32 + 40 + 80 + 120 + 40;
    localparam int CYCLE_LIMIT  = NUM_CMDS * (2 * READ_LATENCY + 8) * 2;

    logic  clk;
    logic  rst;
    logic  cmd_start;
    logic  cmd_write;
    addr_t addr;
    word_t wdata;
    mask_t wmask;
    logic  cmd_ready;
    word_t rdata;
    logic  rdata_valid;
    logic  test_end;
    int    test_num;
    logic  run_end;
    int    error_count;
    int    check_count;
    int    cycle_count;

    always #2 clk = ~clk;

    // Small memory so that the 64 test bytes cover it and wrap
    mem_access_top #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    access_checker #(
        .MODEL_BYTES (MEM_WORDS * WORD_BYTES)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .test_end    (test_end),
        .test_num    (test_num),
        .run_end     (run_end),
        .error_count (error_count),
        .check_count (check_count)
    );

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    // With hold set, start stays high with junk values while busy
    task automatic send_cmd(input logic hold, input logic wr, input addr_t a,
                            input word_t d, input mask_t m);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            if (cmd_ready) begin
                cmd_start = 1'b1;
                cmd_write = wr;
                addr      = a;
                wdata     = d;
                wmask     = m;
                taken     = 1'b1;
            end else if (hold) begin
                cmd_start = 1'b1;
                cmd_write = 1'($urandom);
                addr      = $urandom;
                wdata     = $urandom;
                wmask     = $urandom;
            end else begin
                cmd_start = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        cmd_start = 1'b0;
    endtask

    // Last command finished once ready is back
    task automatic wait_idle();
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic close_test(input int n);
        wait_idle();
        test_num = n;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        addr_t a;
        int    w;
        void'($urandom(63825));
        clk       = 1'b0;
        rst       = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        wmask     = '0;
        test_end  = 1'b0;
        test_num  = 0;
        run_end   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Fill every word, then read it back
        for (int i = 0; i < MEM_WORDS; i++) begin
            send_cmd(1'b0, 1'b1, addr_t'(i * WORD_BYTES), $urandom, '1);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            send_cmd(1'b0, 1'b0, addr_t'(i * WORD_BYTES), '0, '0);
        end
        close_test(1);

        // First read starts in the last word to force the wrap
        for (int i = 0; i < 40; i++) begin
            w = (i == 0) ? MEM_WORDS - 1 : int'($urandom_range(MEM_WORDS - 1, 0));
            a = addr_t'(w * WORD_BYTES + int'($urandom_range(3, 1)));
            send_cmd(1'b0, 1'b0, a, '0, '0);
        end
        close_test(2);

        for (int i = 0; i < 40; i++) begin
            a = addr_t'(int'($urandom_range(MEM_WORDS - 1, 0)) * WORD_BYTES);
            send_cmd(1'b0, 1'b1, a, $urandom, $urandom);
            send_cmd(1'b0, 1'b0, a, '0, '0);
        end
        close_test(3);

        // Read back near the write so neighbour bytes are covered
        for (int i = 0; i < 60; i++) begin
            w = int'($urandom_range(MEM_WORDS - 1, 0));
            a = addr_t'(w * WORD_BYTES + int'($urandom_range(3, 1)));
            send_cmd(1'b0, 1'b1, a, $urandom, $urandom);
            a = addr_t'((int'(a) + 61 + int'($urandom_range(6, 0))) % (MEM_WORDS * WORD_BYTES));
            send_cmd(1'b0, 1'b0, a, '0, '0);
        end
        close_test(4);

        for (int i = 0; i < 40; i++) begin
            a = addr_t'($urandom_range(MEM_WORDS * WORD_BYTES - 1, 0));
            if ($urandom_range(1, 0) == 1) begin
                send_cmd(1'b1, 1'b1, a, $urandom, ($urandom_range(1, 0) == 1) ? '1 : $urandom);
            end else begin
                send_cmd(1'b1, 1'b0, a, '0, '0);
            end
        end
        close_test(5);

        wait_idle();
        run_end = 1'b1;
        @(posedge clk);
        #1;
        $display("%0d reads checked, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run limit from the command count
    initial cycle_count = 0;
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/access_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module access_checker #(
    parameter int MODEL_BYTES = 64
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cmd_start,
    input  wire                       cmd_write,
    input  wire mem_types_pkg::addr_t addr,
    input  wire mem_types_pkg::word_t wdata,
    input  wire mem_types_pkg::mask_t wmask,
    input  wire                       cmd_ready,
    input  wire mem_types_pkg::word_t rdata,
    input  wire                       rdata_valid,
    input  wire                       test_end,
    input  var  int                   test_num,
    input  wire                       run_end,
    output int                        error_count,
    output int                        check_count
);
    import mem_types_pkg::*;

    localparam int IDX_W = $clog2(MODEL_BYTES);

    // Byte-wide reference copy of the memory
    logic [7:0] model_mem [MODEL_BYTES];
    // Expected data of reads still in flight
    word_t      exp_q [$];
    int         reads_accepted;
    int         valid_pulses;
    int         errors_at_test_start;
    int         checks_at_test_start;
    logic       end_checked;
    // A command was taken at the previous edge
    logic       cmd_taken;

    // Four bytes from addr upwards, lowest address in the low byte
    function automatic word_t read_model(input addr_t a);
        word_t            w;
        logic [IDX_W-1:0] idx;
        for (int i = 0; i < WORD_BYTES; i++) begin
            idx         = IDX_W'(a + addr_t'(i));
            w[8*i +: 8] = model_mem[idx];
        end
        return w;
    endfunction

    // Masked update of the four bytes from addr upwards
    task automatic write_model(input addr_t a, input word_t d, input mask_t m);
        logic [IDX_W-1:0] idx;
        logic [7:0]       m8;
        for (int i = 0; i < WORD_BYTES; i++) begin
            idx            = IDX_W'(a + addr_t'(i));
            m8             = m[8*i +: 8];
            model_mem[idx] = (model_mem[idx] & ~m8) | (d[8*i +: 8] & m8);
        end
    endtask

    function automatic string test_name(input int n);
        case (n)
            1:       return "aligned fill and read back";
            2:       return "unaligned reads";
            3:       return "aligned masked writes";
            4:       return "unaligned masked writes";
            5:       return "start held while busy";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        error_count          = 0;
        check_count          = 0;
        reads_accepted       = 0;
        valid_pulses         = 0;
        errors_at_test_start = 0;
        checks_at_test_start = 0;
        end_checked          = 1'b0;
        cmd_taken            = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            // Only one command in flight, so ready drops right after acceptance
            if (cmd_taken && cmd_ready) begin
                $display("ready still high at %0t in the cycle after a command was taken",
                         $time);
                error_count++;
            end
            cmd_taken = cmd_start && cmd_ready;

            // Accepted command updates the model or queues the expected word
            if (cmd_start && cmd_ready) begin
                if (cmd_write) begin
                    write_model(addr, wdata, wmask);
                end else begin
                    exp_q.push_back(read_model(addr));
                    reads_accepted++;
                end
            end

            if (rdata_valid) begin
                valid_pulses++;
                if (exp_q.size() == 0) begin
                    $display("read data valid at %0t with no read outstanding", $time);
                    error_count++;
                end else begin
                    check_count++;
                    if (rdata !== exp_q[0]) begin
                        $display("mismatch at %0t: rdata = %h, expected %h",
                                 $time, rdata, exp_q[0]);
                        error_count++;
                    end
                    void'(exp_q.pop_front());
                end
            end

            // One result line per finished test
            if (test_end) begin
                if (error_count == errors_at_test_start) begin
                    $display("test %0d (%s): PASS, %0d reads checked", test_num,
                             test_name(test_num), check_count - checks_at_test_start);
                end else begin
                    $display("test %0d (%s): FAIL, %0d errors", test_num,
                             test_name(test_num), error_count - errors_at_test_start);
                end
                errors_at_test_start = error_count;
                checks_at_test_start = check_count;
            end

            // Leftovers once all traffic has drained
            if (run_end && !end_checked) begin
                end_checked = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d reads never returned data", exp_q.size());
                    error_count++;
                end
                if (valid_pulses != reads_accepted) begin
                    $display("%0d read data pulses seen for %0d accepted reads",
                             valid_pulses, reads_accepted);
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mem_access_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_access_top #(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cmd_start,
    input  wire                       cmd_write,
    input  wire mem_types_pkg::addr_t addr,
    input  wire mem_types_pkg::word_t wdata,
    input  wire mem_types_pkg::mask_t wmask,
    output logic                      cmd_ready,
    output mem_types_pkg::word_t      rdata,
    output logic                      rdata_valid
);

    // Sequencer to memory word commands
    mem_port_if mem_bus ();

    // Sequencer to byte-lane merge
    lane_if lane_bus ();

    access_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mem         (mem_bus),
        .lanes       (lane_bus)
    );

    lane_merge u_lane_merge (
        .lanes (lane_bus)
    );

    word_memory #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_word_memory (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus)
    );

endmodule

`default_nettype wire

/* logic/word_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module word_memory #(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  wire        clk,
    input  wire        rst,
    mem_port_if.memory mem
);
    import mem_types_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(READ_LATENCY + 1);

    word_t            mem_array [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    // Cycles left until read data is shown
    logic [CNT_W-1:0] lat_count;
    word_t            rdata_q;
    logic             accept_read;
    logic             accept_write;

    // Word index wraps at the memory depth
    assign word_idx = IDX_W'((mem.addr / WORD_BYTES) % MEM_WORDS);

    assign accept_read  = mem.cmd_start && mem.cmd_ready && !mem.cmd_write;
    assign accept_write = mem.cmd_start && mem.cmd_ready && mem.cmd_write;

    // Busy from read acceptance through the valid cycle
    assign mem.cmd_ready   = lat_count == '0;
    assign mem.rdata_valid = lat_count == CNT_W'(1);
    assign mem.rdata       = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lat_count <= '0;
        end else if (accept_read) begin
            lat_count <= CNT_W'(READ_LATENCY);
        end else if (lat_count != '0) begin
            lat_count <= lat_count - 1'b1;
        end
    end

    // Storage array and read data
    always_ff @(posedge clk) begin
        if (accept_write) begin
            mem_array[word_idx] <= mem.wdata;
        end
        if (accept_read) begin
            rdata_q <= mem_array[word_idx];
        end
    end

    // Every valid pulse belongs to a read taken READ_LATENCY cycles before
    assert property (@(posedge clk) disable iff (rst)
        mem.rdata_valid |-> $past(accept_read, READ_LATENCY));

endmodule

`default_nettype wire

/* logic/lane_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_merge (
    lane_if.merger lanes
);
    import mem_types_pkg::*;

    // Two-word window, high word above low word
    localparam int WIN_BITS = 2 * WORD_BITS;

    logic [WIN_BITS-1:0] window;
    logic [WIN_BITS-1:0] data_win;
    logic [WIN_BITS-1:0] mask_win;
    logic [WIN_BITS-1:0] merged_win;
    logic [WIN_BITS-1:0] read_win;
    // Byte offset in bits
    logic [4:0]          shift;

    assign shift  = {lanes.offset, 3'b000};
    assign window = {lanes.high_word, lanes.low_word};

    // Read realignment
    // Byte at addr ends up in the lowest lane
    assign read_win        = window >> shift;
    assign lanes.read_word = read_win[WORD_BITS-1:0];

    // Move new data and mask up to the addressed byte
    assign data_win = WIN_BITS'(lanes.wdata) << shift;
    assign mask_win = WIN_BITS'(lanes.wmask) << shift;

    // Masked bits take new data
    // Unmasked bits keep the word read back
    assign merged_win = (window & ~mask_win) | (data_win & mask_win);

    assign lanes.merged_low  = merged_win[WORD_BITS-1:0];
    // At offset 0 the mask never reaches the high word
    assign lanes.merged_high = merged_win[WIN_BITS-1:WORD_BITS];

endmodule

`default_nettype wire

/* logic/access_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module access_sequencer (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cmd_start,
    input  wire                       cmd_write,
    input  wire mem_types_pkg::addr_t addr,
    input  wire mem_types_pkg::word_t wdata,
    input  wire mem_types_pkg::mask_t wmask,
    output logic                      cmd_ready,
    output mem_types_pkg::word_t      rdata,
    output logic                      rdata_valid,
    mem_port_if.requester             mem,
    lane_if.requester                 lanes
);
    import mem_types_pkg::*;
    import seq_pkg::*;

    seq_state_t state;
    mem_op_t    saved_op;

    // Request captured at acceptance
    addr_t saved_addr;
    word_t saved_wdata;
    mask_t saved_wmask;

    // Words read back from memory
    word_t low_word;
    word_t high_word;

    addr_t first_addr;
    addr_t second_addr;
    logic  unaligned;
    logic  direct_write;

    assign first_addr   = {saved_addr[31:2], 2'b00};
    // Memory indexing folds this back to word 0 past the last word
    assign second_addr  = first_addr + addr_t'(WORD_BYTES);
    assign unaligned    = saved_addr[1:0] != 2'b00;
    // Aligned full-mask write needs no read first
    assign direct_write = saved_op == OP_WRITE && !unaligned && saved_wmask == '1;

    assign lanes.offset    = offset_t'(saved_addr[1:0]);
    assign lanes.wdata     = saved_wdata;
    assign lanes.wmask     = saved_wmask;
    assign lanes.low_word  = low_word;
    assign lanes.high_word = high_word;

    assign cmd_ready   = state == IDLE;
    assign rdata_valid = state == DONE && saved_op == OP_READ;
    assign rdata       = lanes.read_word;

    // Word command for the current state
    always_comb begin
        mem.cmd_start = 1'b0;
        mem.cmd_write = 1'b0;
        mem.addr      = first_addr;
        mem.wdata     = saved_wdata;
        case (state)
            ISSUE_FIRST: begin
                mem.cmd_start = 1'b1;
                mem.cmd_write = direct_write;
            end
            ISSUE_SECOND: begin
                mem.cmd_start = 1'b1;
                mem.addr      = second_addr;
            end
            WRITE_FIRST: begin
                mem.cmd_start = 1'b1;
                mem.cmd_write = 1'b1;
                mem.wdata     = lanes.merged_low;
            end
            WRITE_SECOND: begin
                mem.cmd_start = 1'b1;
                mem.cmd_write = 1'b1;
                mem.addr      = second_addr;
                mem.wdata     = lanes.merged_high;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            saved_op <= OP_READ;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_start) begin
                        saved_op <= cmd_write ? OP_WRITE : OP_READ;
                        state    <= ISSUE_FIRST;
                    end
                end
                ISSUE_FIRST: begin
                    if (mem.cmd_ready) begin
                        state <= direct_write ? DONE : WAIT_FIRST;
                    end
                end
                WAIT_FIRST: begin
                    if (mem.rdata_valid) begin
                        if (unaligned) begin
                            state <= ISSUE_SECOND;
                        end else begin
                            state <= saved_op == OP_READ ? DONE : WRITE_FIRST;
                        end
                    end
                end
                ISSUE_SECOND: begin
                    if (mem.cmd_ready) begin
                        state <= WAIT_SECOND;
                    end
                end
                WAIT_SECOND: begin
                    if (mem.rdata_valid) begin
                        state <= saved_op == OP_READ ? DONE : WRITE_FIRST;
                    end
                end
                WRITE_FIRST: begin
                    if (mem.cmd_ready) begin
                        state <= unaligned ? WRITE_SECOND : DONE;
                    end
                end
                WRITE_SECOND: begin
                    if (mem.cmd_ready) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Payload and read-back words
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_start) begin
            saved_addr  <= addr;
            saved_wdata <= wdata;
            saved_wmask <= wmask;
        end
        if (state == WAIT_FIRST && mem.rdata_valid) begin
            low_word <= mem.rdata;
        end
        if (state == WAIT_SECOND && mem.rdata_valid) begin
            high_word <= mem.rdata;
        end
    end

    // Never send a command the memory cannot take
    assert property (@(posedge clk) disable iff (rst)
        mem.cmd_start |-> mem.cmd_ready);

    // Read result only right after the last read word came back
    assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> state == DONE && $past(state) inside {WAIT_FIRST, WAIT_SECOND});

endmodule

`default_nettype wire

/* logic/lane_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface lane_if;
    import mem_types_pkg::*;

    // Saved request and the two words read back
    offset_t offset;
    word_t   wdata;
    mask_t   wmask;
    word_t   low_word;
    word_t   high_word;

    // Merged words for write back and realigned read result
    word_t   merged_low;
    word_t   merged_high;
    word_t   read_word;

    modport requester (
        output offset, wdata, wmask, low_word, high_word,
        input  merged_low, merged_high, read_word
    );

    modport merger (
        input  offset, wdata, wmask, low_word, high_word,
        output merged_low, merged_high, read_word
    );

endinterface

`default_nettype wire

/* logic/mem_port_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if;
    import mem_types_pkg::*;

    // Command from the sequencer
    logic  cmd_start;
    logic  cmd_write;
    // Always word aligned
    addr_t addr;
    word_t wdata;

    // Status and read data from the memory
    logic  cmd_ready;
    word_t rdata;
    logic  rdata_valid;

    modport requester (
        output cmd_start, cmd_write, addr, wdata,
        input  cmd_ready, rdata, rdata_valid
    );

    modport memory (
        input  cmd_start, cmd_write, addr, wdata,
        output cmd_ready, rdata, rdata_valid
    );

endinterface

`default_nettype wire

/* logic/seq_pkg.sv */
`default_nettype none

package seq_pkg;

    // Sequencer states
    // Issue and write states each send one word command to memory
    typedef enum logic [2:0] {
        IDLE,
        ISSUE_FIRST,
        WAIT_FIRST,
        ISSUE_SECOND,
        WAIT_SECOND,
        WRITE_FIRST,
        WRITE_SECOND,
        DONE
    } seq_state_t;

    // Kind of the request held by the sequencer
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_t;

endpackage

`default_nettype wire

/* logic/mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

    // Bytes in one memory word
    localparam int WORD_BYTES = 4;

    // Bits in one memory word
    localparam int WORD_BITS = WORD_BYTES * 8;

    // Byte address as seen by the caller
    typedef logic [31:0] addr_t;

    // One memory word of data
    typedef logic [WORD_BITS-1:0] word_t;

    // Bit-level write enable, bit i guards data bit i
    typedef logic [WORD_BITS-1:0] mask_t;

    // Byte position of an address inside its word
    typedef logic [$clog2(WORD_BYTES)-1:0] offset_t;

endpackage

`default_nettype wire
